// File: verilog/mskPkg.sv
package mskPkg;

	////////////////////////////////////////
	// Host side and FIFO storage
	////////////////////////////////////////

	// One host write carries a nibble
	localparam int NIBBLE_WIDTH    = 4;
	localparam int FIFO_DEPTH      = 8;
	localparam int FIFO_BITS       = FIFO_DEPTH * NIBBLE_WIDTH;
	localparam int PTR_WIDTH       = $clog2(FIFO_DEPTH);
	localparam int BIT_INDEX_WIDTH = $clog2(NIBBLE_WIDTH);
	// Counter has to reach FIFO_BITS itself
	localparam int COUNT_WIDTH     = $clog2(FIFO_BITS + 1);

	////////////////////////////////////////
	// Modulator timing and shaping
	////////////////////////////////////////

	// Signed two's complement I and Q samples
	localparam int SAMPLE_WIDTH    = 4;
	// Clocks per consumed bit, also the Q offset in samples
	localparam int SAMPLES_PER_BIT = 4;
	// One I or Q symbol spans two bit periods
	localparam int SYMBOL_PHASES   = 8;
	localparam int PHASE_WIDTH     = $clog2(SYMBOL_PHASES);
	localparam int MAG_WIDTH       = 3;

	// Phase of the Q pop point
	localparam logic [PHASE_WIDTH-1:0] Q_OFFSET = PHASE_WIDTH'(SAMPLES_PER_BIT);

	// Half-sine magnitudes, indexed by symbol phase
	localparam logic [MAG_WIDTH-1:0] HALF_SINE [SYMBOL_PHASES] = '{
		3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd6, 3'd4, 3'd2
	};

endpackage

// File: verilog/bitFifo.sv
`timescale 1ns/1ps

module bitFifo (
	input  logic                            i_clock,
	input  logic                            i_reset,

	input  logic                            i_writeEnable,
	input  logic [mskPkg::NIBBLE_WIDTH-1:0] i_data,
	input  logic                            i_readEnable,

	output logic                            o_bit,
	output logic                            o_empty,
	output logic                            o_full
);
	import mskPkg::*;

	////////////////////////////////////////
	// Storage and pointers
	////////////////////////////////////////

	logic [NIBBLE_WIDTH-1:0]    mem [FIFO_DEPTH];

	logic [PTR_WIDTH-1:0]       writePtr;
	logic [PTR_WIDTH-1:0]       readPtr;
	// Position of the head bit inside the head nibble
	logic [BIT_INDEX_WIDTH-1:0] bitIndex;
	// Number of bits held, 0 to FIFO_BITS
	logic [COUNT_WIDTH-1:0]     bitCount;

	logic                       writeAccept;
	logic                       popAccept;
	logic                       lastBitOfNibble;
	logic [NIBBLE_WIDTH-1:0]    headNibble;

	////////////////////////////////////////
	// Levels and strobes
	////////////////////////////////////////

	// Empty and full come from the bit counter only
	assign o_empty = (bitCount == '0);

	// Full means no room left for a whole nibble
	assign o_full  = (bitCount > COUNT_WIDTH'(FIFO_BITS - NIBBLE_WIDTH));

	// A write into a full FIFO is simply lost
	assign writeAccept = i_writeEnable && !o_full;
	assign popAccept   = i_readEnable && !o_empty;

	assign lastBitOfNibble = (bitIndex == BIT_INDEX_WIDTH'(NIBBLE_WIDTH - 1));

	// First word fall through, LSB of each nibble goes out first
	assign headNibble = mem[readPtr];
	assign o_bit      = headNibble[bitIndex];

	////////////////////////////////////////
	// Nibble memory
	////////////////////////////////////////

	always_ff @(posedge i_clock) begin
		if (writeAccept) begin
			mem[writePtr] <= i_data;
		end
	end

	////////////////////////////////////////
	// Pointer and counter update
	////////////////////////////////////////

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			writePtr <= '0;
			readPtr  <= '0;
			bitIndex <= '0;
			bitCount <= '0;
		end else begin
			if (writeAccept) begin
				writePtr <= writePtr + PTR_WIDTH'(1);
			end

			// Bit index wraps on its own, read pointer follows it
			if (popAccept) begin
				bitIndex <= bitIndex + BIT_INDEX_WIDTH'(1);
				if (lastBitOfNibble) begin
					readPtr <= readPtr + PTR_WIDTH'(1);
				end
			end

			// Write and pop in one cycle are both honored
			case ({writeAccept, popAccept})
				2'b10: begin
					bitCount <= bitCount + COUNT_WIDTH'(NIBBLE_WIDTH);
				end
				2'b01: begin
					bitCount <= bitCount - COUNT_WIDTH'(1);
				end
				2'b11: begin
					bitCount <= bitCount + COUNT_WIDTH'(NIBBLE_WIDTH - 1);
				end
				default: begin
					bitCount <= bitCount;
				end
			endcase
		end
	end

endmodule

// File: verilog/mskModulator.sv
`timescale 1ns/1ps

module mskModulator (
	input  logic                                   i_clock,
	input  logic                                   i_reset,

	// Head of the bit FIFO
	input  logic                                   i_bit,
	input  logic                                   i_empty,
	output logic                                   o_read,

	// Sample stream
	output logic                                   o_active,
	output logic signed [mskPkg::SAMPLE_WIDTH-1:0] o_sinI,
	output logic signed [mskPkg::SAMPLE_WIDTH-1:0] o_sinQ
);
	import mskPkg::*;

	////////////////////////////////////////
	// State
	////////////////////////////////////////

	logic                           running;
	// Phase of the current cycle, one ahead of the sample it registers
	logic [PHASE_WIDTH-1:0]         phase;
	// Symbols hold +1, -1, or 0 before the first bit of a run
	logic signed [1:0]              symI;
	logic signed [1:0]              symQ;

	////////////////////////////////////////
	// Combinational helpers
	////////////////////////////////////////

	logic                           popPoint;
	logic signed [1:0]              newSymbol;
	logic [PHASE_WIDTH-1:0]         shapePhaseI;
	logic [PHASE_WIDTH-1:0]         shapePhaseQ;
	logic signed [SAMPLE_WIDTH-1:0] nextSinI;
	logic signed [SAMPLE_WIDTH-1:0] nextSinQ;

	// Symbol times half-sine magnitude
	function automatic logic signed [SAMPLE_WIDTH-1:0] shapeSample(
		input logic signed [1:0]     symbol,
		input logic [MAG_WIDTH-1:0]  magnitude
	);
		logic signed [SAMPLE_WIDTH-1:0] scaled;
		scaled = signed'({{(SAMPLE_WIDTH - MAG_WIDTH){1'b0}}, magnitude});
		case (symbol)
			2'sb01: begin
				shapeSample = scaled;
			end
			2'sb11: begin
				shapeSample = -scaled;
			end
			default: begin
				shapeSample = '0;
			end
		endcase
	endfunction

	// Pop points every SAMPLES_PER_BIT clocks, I at 0 and Q at the offset.
	// Idle always sits at phase 0, so a waiting bit is taken right away
	assign popPoint = (phase == '0) || (phase == Q_OFFSET);
	assign o_read   = popPoint && !i_empty;

	// Bit 1 maps to +1, bit 0 to -1
	assign newSymbol = i_bit ? 2'sb01 : 2'sb11;

	// Sample registered this cycle belongs to the previous phase
	assign shapePhaseI = phase - PHASE_WIDTH'(1);
	// Q runs SAMPLES_PER_BIT behind I
	assign shapePhaseQ = shapePhaseI + Q_OFFSET;

	assign nextSinI = shapeSample(symI, HALF_SINE[shapePhaseI]);
	assign nextSinQ = shapeSample(symQ, HALF_SINE[shapePhaseQ]);

	////////////////////////////////////////
	// Run control, symbols and samples
	////////////////////////////////////////

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			running  <= 1'b0;
			phase    <= '0;
			symI     <= '0;
			symQ     <= '0;
			o_active <= 1'b0;
			o_sinI   <= '0;
			o_sinQ   <= '0;
		end else if (!running) begin
			// Start of a run, first bit always lands on I
			if (!i_empty) begin
				running <= 1'b1;
				symI    <= newSymbol;
				phase   <= PHASE_WIDTH'(1);
			end
		end else if (popPoint && i_empty) begin
			// Underflow, drop back to idle and silence both channels
			running  <= 1'b0;
			phase    <= '0;
			symI     <= '0;
			symQ     <= '0;
			o_active <= 1'b0;
			o_sinI   <= '0;
			o_sinQ   <= '0;
		end else begin
			o_active <= 1'b1;
			o_sinI   <= nextSinI;
			o_sinQ   <= nextSinQ;
			phase    <= phase + PHASE_WIDTH'(1);

			// New symbol shows up from the next sample on
			if (o_read) begin
				if (phase == '0) begin
					symI <= newSymbol;
				end else begin
					symQ <= newSymbol;
				end
			end
		end
	end

endmodule

// File: verilog/mskTransmitter.sv
`timescale 1ns/1ps

module mskTransmitter (
	input  logic                                   i_clock,
	input  logic                                   i_reset,

	input  logic                                   i_writeEnable,
	input  logic [mskPkg::NIBBLE_WIDTH-1:0]        i_data,
	output logic                                   o_full,

	output logic                                   o_active,
	output logic signed [mskPkg::SAMPLE_WIDTH-1:0] o_sinI,
	output logic signed [mskPkg::SAMPLE_WIDTH-1:0] o_sinQ
);

	////////////////////////////////////////
	// FIFO to modulator wires
	////////////////////////////////////////

	logic fifoBit;
	logic fifoEmpty;
	logic fifoRead;

	////////////////////////////////////////
	// Bit FIFO
	////////////////////////////////////////

	bitFifo u_bitFifo (
		.i_clock       (i_clock       ),
		.i_reset       (i_reset       ),
		.i_writeEnable (i_writeEnable ),
		.i_data        (i_data        ),
		.i_readEnable  (fifoRead      ),
		.o_bit         (fifoBit       ),
		.o_empty       (fifoEmpty     ),
		.o_full        (o_full        )
	);

	////////////////////////////////////////
	// MSK modulator
	////////////////////////////////////////

	mskModulator u_modulator (
		.i_clock       (i_clock       ),
		.i_reset       (i_reset       ),
		.i_bit         (fifoBit       ),
		.i_empty       (fifoEmpty     ),
		.o_read        (fifoRead      ),
		.o_active      (o_active      ),
		.o_sinI        (o_sinI        ),
		.o_sinQ        (o_sinQ        )
	);

endmodule

// File: tb/mskTransmitter_sva.sv
`timescale 1ns/1ps

module mskTransmitter_sva (
	input  logic                                   i_clock,
	input  logic                                   i_reset,
	input  logic                                   i_read,
	input  logic                                   i_active,
	input  logic [mskPkg::COUNT_WIDTH-1:0]         i_bitCount,
	input  logic signed [mskPkg::SAMPLE_WIDTH-1:0] i_sinI,
	input  logic signed [mskPkg::SAMPLE_WIDTH-1:0] i_sinQ
);
	import mskPkg::*;

	// Each pop takes a bit the FIFO really holds, with or without a write
	readNotEmpty: assert property (@(posedge i_clock) disable iff (i_reset)
		i_read |=> (i_bitCount == $past(i_bitCount) - COUNT_WIDTH'(1))
			|| (i_bitCount == $past(i_bitCount) + COUNT_WIDTH'(NIBBLE_WIDTH - 1)))
		else $error("pop strobe while FIFO empty");

	// At most one pop per bit period
	readSpacing: assert property (@(posedge i_clock) disable iff (i_reset)
		i_read |=> !i_read ##1 !i_read ##1 !i_read)
		else $error("pop strobes closer than one bit period");

	countInRange: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bitCount <= COUNT_WIDTH'(FIFO_BITS)) else $error("FIFO bit count above capacity");

	// Silent channels while idle
	idleQuiet: assert property (@(posedge i_clock) disable iff (i_reset)
		!i_active |-> (i_sinI == '0 && i_sinQ == '0))
		else $error("nonzero sample while inactive");

endmodule

bind mskTransmitter mskTransmitter_sva u_sva (
	.i_clock    (i_clock                 ),
	.i_reset    (i_reset                 ),
	.i_read     (fifoRead                ),
	.i_active   (o_active                ),
	.i_bitCount (u_bitFifo.bitCount      ),
	.i_sinI     (o_sinI                  ),
	.i_sinQ     (o_sinQ                  )
);

// File: tb/mskTransmitter_tb.sv
`timescale 1ns/1ps

module mskTransmitter_tb;
	import mskPkg::*;

	localparam int TIMEOUT = 400;

	logic                           clock;
	logic                           reset;
	logic                           writeEnable;
	logic [NIBBLE_WIDTH-1:0]        data;
	logic                           full;
	logic                           active;
	logic signed [SAMPLE_WIDTH-1:0] sinI;
	logic signed [SAMPLE_WIDTH-1:0] sinQ;

	logic signed [SAMPLE_WIDTH-1:0] gotI [$];
	logic signed [SAMPLE_WIDTH-1:0] gotQ [$];
	logic signed [SAMPLE_WIDTH-1:0] expI [$];
	logic signed [SAMPLE_WIDTH-1:0] expQ [$];

	logic [8*72-1:0] tok;
	logic [8*72-1:0] hexTok;
	logic [8*32-1:0] testName;
	logic [8*200-1:0] lineBuf;
	logic [31:0]     lcgState = 32'h12de;
	logic            idleCheckOn = 1'b0;
	logic            prevActive = 1'b0;
	logic            latencyArmed = 1'b0;
	logic            inTest = 1'b0;
	logic            timedOut = 1'b0;
	int              edgeCount = 0;
	int              riseEdge = 0;
	int              writeEdge = -1;
	int              expLatency = 0;
	int              errorCount = 0;
	int              errorsAtStart = 0;
	int              testCount = 0;
	int              failedTests = 0;

	mskTransmitter u_dut (
		.i_clock       (clock       ),
		.i_reset       (reset       ),
		.i_writeEnable (writeEnable ),
		.i_data        (data        ),
		.o_full        (full        ),
		.o_active      (active      ),
		.o_sinI        (sinI        ),
		.o_sinQ        (sinQ        )
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) edgeCount <= edgeCount + 1;

	////////////////////////////////////////
	// Checks and helpers
	////////////////////////////////////////

	task automatic checkSample(input string what, input logic signed [SAMPLE_WIDTH-1:0] expected,
			input logic signed [SAMPLE_WIDTH-1:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("** Error %0s: %0s expected %0d actual %0d", testName, what, expected, actual);
		end
	endtask

	task automatic checkLevel(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("** Error %0s: %0s expected %0b actual %0b", testName, what, expected, actual);
		end
	endtask

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Hex digit of a trace token, as a signed sample
	function automatic logic signed [SAMPLE_WIDTH-1:0] hexDigit(input logic [7:0] c);
		if (c >= "0" && c <= "9") return SAMPLE_WIDTH'(c - "0");
		return SAMPLE_WIDTH'(c - "A" + 8'd10);
	endfunction

	task automatic appendHex(input logic [8*72-1:0] digits, input logic toQ);
		logic [7:0] c;
		for (int b = 71; b >= 0; b--) begin
			c = digits[b*8 +: 8];
			if (c != 8'd0) begin
				if (toQ) expQ.push_back(hexDigit(c));
				else expI.push_back(hexDigit(c));
			end
		end
	endtask

	task automatic reportTimeout(input string what);
		errorCount++;
		timedOut = 1'b1;
		$display("timeout while waiting for %0s in test %0s", what, testName);
	endtask

	// Gap -1 picks 0 to 3 idle cycles, short enough to keep the FIFO fed
	task automatic writeNibbles(input logic [NIBBLE_WIDTH-1:0] nibble, input int gap,
			input int count);
		int idle;
		for (int n = 0; n < count; n++) begin
			if (latencyArmed && writeEdge < 0) writeEdge = edgeCount + 1;
			writeEnable = 1'b1;
			data = nibble;
			@(negedge clock);
			writeEnable = 1'b0;
			idle = gap;
			if (gap < 0) begin
				lcgState = nextRandom(lcgState);
				idle = int'(lcgState[17:16]);
			end
			repeat (idle) @(negedge clock);
		end
	endtask

	task automatic runCheck();
		int waited;
		waited = 0;
		while ((gotI.size() < expI.size() || active) && waited < TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (waited >= TIMEOUT) begin
			reportTimeout("the end of a sample run");
		end else begin
			if (gotI.size() != expI.size()) begin
				errorCount++;
				$display("** Error %0s: sample count expected %0d actual %0d",
					testName, expI.size(), gotI.size());
			end
			for (int i = 0; i < expI.size() && i < gotI.size(); i++) begin
				checkSample($sformatf("sinI[%0d]", i), expI[i], gotI[i]);
				checkSample($sformatf("sinQ[%0d]", i), expQ[i], gotQ[i]);
			end
			if (latencyArmed && riseEdge - writeEdge != expLatency) begin
				errorCount++;
				$display("** Error %0s: start latency expected %0d actual %0d",
					testName, expLatency, riseEdge - writeEdge);
			end
			latencyArmed = 1'b0;
			gotI.delete();
			gotQ.delete();
			expI.delete();
			expQ.delete();
		end
	endtask

	task automatic resetPulse();
		reset = 1'b1;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		checkLevel("o_active after reset", 1'b0, active);
		checkLevel("o_full after reset", 1'b0, full);
		checkSample("sinI after reset", '0, sinI);
		checkSample("sinQ after reset", '0, sinQ);
		gotI.delete();
		gotQ.delete();
	endtask

	task automatic finishTest();
		if (inTest) begin
			if (errorCount == errorsAtStart) begin
				$display("test %0s: passed", testName);
			end else begin
				failedTests++;
				$display("test %0s: failed with %0d errors", testName, errorCount - errorsAtStart);
			end
		end
	endtask

	////////////////////////////////////////
	// Sample collection on the falling edge
	////////////////////////////////////////

	always @(negedge clock) begin
		if (active) begin
			if (!prevActive) riseEdge = edgeCount;
			gotI.push_back(sinI);
			gotQ.push_back(sinQ);
		end else if (idleCheckOn) begin
			checkSample("idle sinI", '0, sinI);
			checkSample("idle sinQ", '0, sinQ);
		end
		prevActive = active;
	end

	////////////////////////////////////////
	// Trace interpreter
	////////////////////////////////////////

	initial begin
		int fd;
		int code;
		int gap;
		int count;
		logic [NIBBLE_WIDTH-1:0] nibble;
		reset = 1'b1;
		writeEnable = 1'b0;
		data = '0;
		testName = "setup";
		repeat (16) @(negedge clock);
		reset = 1'b0;
		idleCheckOn = 1'b1;
		fd = $fopen("tb/msk_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file tb/msk_trace.txt");
			$display("=== FAIL ===");
			$finish;
		end else begin
			while (!timedOut && $fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					code = $fgets(lineBuf, fd);
				end else if (tok == "T") begin
					finishTest();
					code = $fscanf(fd, "%s", testName);
					errorsAtStart = errorCount;
					inTest = 1'b1;
					testCount++;
				end else if (tok == "W") begin
					code = $fscanf(fd, "%h %d %d", nibble, gap, count);
					writeNibbles(nibble, gap, count);
				end else if (tok == "F") begin
					checkLevel("o_full", 1'b1, full);
				end else if (tok == "L") begin
					code = $fscanf(fd, "%d", expLatency);
					latencyArmed = 1'b1;
					writeEdge = -1;
				end else if (tok == "I" || tok == "Q") begin
					code = $fscanf(fd, "%s", hexTok);
					appendHex(hexTok, tok == "Q");
				end else if (tok == "X") begin
					runCheck();
				end else if (tok == "R") begin
					resetPulse();
				end
			end
			$fclose(fd);
			finishTest();
			$display("%0d tests, %0d passed, %0d failed, %0d errors",
				testCount, testCount - failedTests, failedTests, errorCount);
			if (errorCount == 0 && failedTests == 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
			$finish;
		end
	end

endmodule

// File: tb/msk_trace.txt
# T name | W nibble gap count (gap -1 random) | L edges | I/Q hex samples | X check run
# F o_full high | R reset pulse
T continuous
W 9 0 1
W 3 0 1
W C 0 1
W 6 0 1
I 024676420ECA9ACE024676420ECA9ACE0ECA9ACE024676420ECA9ACE0246764
Q 00000ECA9ACE02467642024676420ECA9ACE0ECA9ACE02467642024676420EC
X
T latency
L 2
W A 0 1
I 0ECA9ACE0ECA9AC
Q 000002467642024
X
T underflow
W 5 20 1
I 024676420246764
Q 00000ECA9ACE0EC
X
L 2
W 2 0 1
I 0ECA9ACE0ECA9AC
Q 0000024676420EC
X
T overflow
W 9 0 8
F
W F 0 1
I 024676420ECA9ACE024676420ECA9ACE024676420ECA9ACE024676420ECA9ACE
I 024676420ECA9ACE024676420ECA9ACE024676420ECA9ACE024676420ECA9AC
Q 00000ECA9ACE024676420ECA9ACE024676420ECA9ACE024676420ECA9ACE0246
Q 76420ECA9ACE024676420ECA9ACE024676420ECA9ACE024676420ECA9ACE024
X
T reset
W 1 0 8
F
R
W 9 -1 1
W 3 -1 1
W C -1 1
W 6 -1 1
I 024676420ECA9ACE024676420ECA9ACE0ECA9ACE024676420ECA9ACE0246764
Q 00000ECA9ACE02467642024676420ECA9ACE0ECA9ACE02467642024676420EC
X

// File: list.f
verilog/mskPkg.sv
verilog/bitFifo.sv
verilog/mskModulator.sv
verilog/mskTransmitter.sv
tb/mskTransmitter_sva.sv
tb/mskTransmitter_tb.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module mskTransmitter_tb -f list.f

sim:
	verilator --binary --timing --assert --top-module mskTransmitter_tb -f list.f -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	cat sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
